//--- files.f
+incdir+.
exConvPkg.sv
exConv2R.sv
exOpClz.sv
exConvUnit.sv
tb_exConvUnit.sv

//--- runSim.sh
#!/bin/sh
# Builds the conversion lane testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module tb_exConvUnit -o simExConv
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/simExConv 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q '^TESTBENCH PASSED$'; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- tb_exConvUnit.sv
// Directed testbench for the conversion lane top level, with reference model and timeout.
`timescale 1ns/1ps
`default_nettype none

`include "exConv_settings.svh"

module tb_exConvUnit;

	localparam int W          = `EXCONV_DATA_W;
	localparam int HI_W       = `EXCONV_UIXT_W - `EXCONV_OP_W;
	localparam int MAX_CYCLES = 2000;
	localparam logic [W-1:0] SIGN_BIT = {1'b1, {(W-1){1'b0}}};

	logic                      clock;
	logic                      rstN;
	logic                      inValid;
	logic [W-1:0]              regValRs;
	logic [`EXCONV_UIXT_W-1:0] idUIxt;
	logic                      regInSrT;
	logic                      outValid;
	logic [W-1:0]              regOutVal;
	logic                      regOutSrT;

	int          errCount;
	int          checkCount;
	int          cycleCount;
	logic [63:0] rngState;
	// What the result registers should hold after the last accepted request.
	logic [W-1:0] lastVal;
	logic         lastSrT;

	exConvUnit UUT (
		.clock     (clock),
		.rstN      (rstN),
		.inValid   (inValid),
		.regValRs  (regValRs),
		.idUIxt    (idUIxt),
		.regInSrT  (regInSrT),
		.outValid  (outValid),
		.regOutVal (regOutVal),
		.regOutSrT (regOutSrT)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic [63:0] nextRandom();
		logic [63:0] s;
		s = rngState;
		s = s ^ (s << 13);
		s = s ^ (s >> 7);
		s = s ^ (s << 17);
		rngState = s;
		return s;
	endfunction

	// Expected result, built straight from the operation table.
	function automatic logic [W-1:0] expectedResult(
		input logic [`EXCONV_OP_W-1:0] code,
		input logic [W-1:0]            v
	);
		int           cnt;
		logic [W-1:0] res;
		cnt = 0;
		case (code)
			exConvPkg::opExtsb:    res = W'($signed(v[7:0]));
			exConvPkg::opExtsw:    res = W'($signed(v[15:0]));
			exConvPkg::opExtsl:    res = W'($signed(v[31:0]));
			exConvPkg::opMov:      res = v;
			exConvPkg::opExtub:    res = v & 64'h0000_0000_0000_00FF;
			exConvPkg::opExtuw:    res = v & 64'h0000_0000_0000_FFFF;
			exConvPkg::opExtul:    res = v & 64'h0000_0000_FFFF_FFFF;
			exConvPkg::opNot:      res = ~v;
			exConvPkg::opClz: begin
				while (cnt < 32 && !v[31 - cnt])
					cnt++;
				res = W'(cnt);
			end
			exConvPkg::opClzq: begin
				while (cnt < 64 && !v[63 - cnt])
					cnt++;
				res = W'(cnt);
			end
			exConvPkg::opLdihi:    res = v << 22;
			exConvPkg::opLdiqhi:   res = v << 54;
			exConvPkg::opLdiqhi16: res = v << 16;
			exConvPkg::opLdiqhi32: res = v << 32;
			exConvPkg::opFneg:     res = v ^ SIGN_BIT;
			exConvPkg::opFabs:     res = v & ~SIGN_BIT;
			default:               res = '0;
		endcase
		return res;
	endfunction

	task automatic checkWord(input string what, input logic [W-1:0] got, input logic [W-1:0] exp);
		checkCount++;
		assert (got === exp) else begin
			errCount++;
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkBit(input string what, input logic got, input logic exp);
		checkCount++;
		assert (got === exp) else begin
			errCount++;
			$display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Drives one strobe and checks its result on the following cycle.
	// Successive calls keep inValid high, so they stream back to back.
	task automatic applyAndCheck(
		input logic [`EXCONV_OP_W-1:0] code,
		input logic [HI_W-1:0]         hiBits,
		input logic [W-1:0]            val,
		input logic                    srT
	);
		logic [W-1:0] exp;
		exp = expectedResult(code, val);
		inValid = 1'b1;
		idUIxt = {hiBits, code};
		regValRs = val;
		regInSrT = srT;
		@(posedge clock);
		#1;
		lastVal = exp;
		lastSrT = srT;
		checkBit($sformatf("outValid for op %0d", code), outValid, 1'b1);
		checkWord($sformatf("result of op %0d on %h", code, val), regOutVal, exp);
		checkBit($sformatf("regOutSrT for op %0d", code), regOutSrT, srT);
	endtask

	task automatic idleAndCheck(input int n);
		inValid = 1'b0;
		repeat (n) begin
			regValRs = nextRandom();
			@(posedge clock);
			#1;
			checkBit("outValid while idle", outValid, 1'b0);
			checkWord("held regOutVal", regOutVal, lastVal);
			checkBit("held regOutSrT", regOutSrT, lastSrT);
		end
	endtask

	task automatic finishTest(input string name, input int errsAtStart);
		if (errCount == errsAtStart) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errCount - errsAtStart);
		end
	endtask

	task automatic resetBehavior();
		int errsAtStart;
		errsAtStart = errCount;
		rstN = 1'b0;
		repeat (4) begin
			@(posedge clock);
			#1;
			checkBit("outValid in reset", outValid, 1'b0);
			checkWord("regOutVal in reset", regOutVal, '0);
			checkBit("regOutSrT in reset", regOutSrT, 1'b0);
		end
		rstN = 1'b1;
		lastVal = '0;
		lastSrT = 1'b0;
		idleAndCheck(2);
		finishTest("reset", errsAtStart);
	endtask

	task automatic extendAndMove();
		int           errsAtStart;
		logic [W-1:0] val;
		logic [63:0]  r;
		errsAtStart = errCount;
		for (int k = 0; k < 45; k++) begin
			case (k)
				0:       val = '0;
				1:       val = '1;
				2:       val = 64'h8000_0000_8000_8080;
				3:       val = 64'h7FFF_FFFF_7FFF_7F7F;
				4:       val = 64'h0123_4567_89AB_CDEF;
				default: val = nextRandom();
			endcase
			for (int c = 0; c < 8; c++) begin
				r = nextRandom();
				applyAndCheck(6'(c), '0, val, r[0]);
			end
		end
		finishTest("extend, move and not", errsAtStart);
	endtask

	task automatic leadingZeroCount();
		int           errsAtStart;
		logic [W-1:0] val;
		logic [63:0]  r;
		errsAtStart = errCount;
		for (int k = 0; k < 86; k++) begin
			r = nextRandom();
			if (k == 0) begin
				val = '0;
			end else if (k == 1) begin
				val = '1;
			end else if (k < 66) begin
				val = W'(1) << (k - 2);
			end else begin
				val = nextRandom() >> r[5:0];
			end
			applyAndCheck(exConvPkg::opClz, '0, val, r[0]);
			applyAndCheck(exConvPkg::opClzq, '0, val, ~r[0]);
		end
		finishTest("leading-zero count", errsAtStart);
	endtask

	task automatic immediateHighAndSign();
		int           errsAtStart;
		logic [W-1:0] val;
		errsAtStart = errCount;
		for (int k = 0; k < 20; k++) begin
			val = nextRandom();
			for (int c = 10; c < 16; c++) begin
				applyAndCheck(6'(c), '0, val, val[0]);
			end
		end
		// Undefined opcodes must come out as zero.
		applyAndCheck(6'd16, '0, val, 1'b1);
		applyAndCheck(6'd42, 2'b11, nextRandom(), 1'b0);
		applyAndCheck(6'd63, '0, '1, 1'b1);
		finishTest("immediate-high, sign and undefined", errsAtStart);
	endtask

	task automatic backToBackStream();
		int          errsAtStart;
		int          pulses;
		logic [63:0] r;
		errsAtStart = errCount;
		pulses = 0;
		for (int k = 0; k < 30; k++) begin
			r = nextRandom();
			applyAndCheck({2'b00, r[3:0]}, r[5:4], nextRandom(), r[6]);
			if (outValid === 1'b1) begin
				pulses++;
			end
		end
		checkWord("number of output pulses", W'(pulses), W'(30));
		idleAndCheck(3);
		applyAndCheck(exConvPkg::opNot, '0, nextRandom(), 1'b1);
		idleAndCheck(2);
		applyAndCheck(exConvPkg::opClzq, '0, 64'h0000_0F00_0000_0000, 1'b0);
		idleAndCheck(2);
		finishTest("throughput", errsAtStart);
	endtask

	initial begin
		errCount = 0;
		checkCount = 0;
		rngState = 64'd56458;
		rstN = 1'b0;
		inValid = 1'b0;
		regValRs = '0;
		idUIxt = '0;
		regInSrT = 1'b0;
		lastVal = '0;
		lastSrT = 1'b0;
		resetBehavior();
		extendAndMove();
		leadingZeroCount();
		immediateHighAndSign();
		backToBackStream();
		$display("Summary: %0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// The whole run takes about 700 cycles, so the limit leaves ample margin.
	initial begin
		cycleCount = 0;
		while (cycleCount < MAX_CYCLES) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- exConvUnit.sv
// Top level of the conversion lane: both units, result select and output register.
`timescale 1ns/1ps
`default_nettype none

`include "exConv_settings.svh"

module exConvUnit (
	input  wire logic                      clock,
	input  wire logic                      rstN,
	input  wire logic                      inValid,
	input  wire logic [`EXCONV_DATA_W-1:0] regValRs,
	input  wire logic [`EXCONV_UIXT_W-1:0] idUIxt,
	input  wire logic                      regInSrT,
	output logic                           outValid,
	output logic      [`EXCONV_DATA_W-1:0] regOutVal,
	output logic                           regOutSrT
);

	localparam int W = `EXCONV_DATA_W;

	logic [W-1:0] convVal;
	logic [W-1:0] clzVal;
	logic         clzHit;
	logic [W-1:0] selVal;

	// Both units see the same operand and decode their own opcodes.
	exConv2R conv2R (
		.regValRs (regValRs),
		.idUIxt   (idUIxt),
		.convVal  (convVal)
	);

	exOpClz opClz (
		.regValRs (regValRs),
		.idUIxt   (idUIxt),
		.clzVal   (clzVal),
		.clzHit   (clzHit)
	);

	// The counter claims its operations, everything else comes from the converter.
	assign selVal = clzHit ? clzVal : convVal;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= inValid;
		end
	end

	// Result and flag load only on an accepted request and hold otherwise.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			regOutVal <= '0;
			regOutSrT <= 1'b0;
		end else if (inValid) begin
			regOutVal <= selVal;
			regOutSrT <= regInSrT;
		end
	end

	// The valid strobe must be clean once reset is released.
	property pValidKnown;
		@(posedge clock) disable iff (!rstN)
			!$isunknown(outValid);
	endproperty
	aValidKnown: assert property (pValidKnown)
		else $error("outValid is unknown after reset");

	// A claimed count can never exceed the word width.
	property pClzRange;
		@(posedge clock) disable iff (!rstN)
			clzHit |-> (clzVal <= W);
	endproperty
	aClzRange: assert property (pClzRange)
		else $error("leading-zero count out of range");

endmodule

`default_nettype wire

//--- exOpClz.sv
// Combinational leading-zero counter for the CLZ and CLZQ operations.
`timescale 1ns/1ps
`default_nettype none

`include "exConv_settings.svh"

module exOpClz (
	input  wire logic [`EXCONV_DATA_W-1:0] regValRs,
	input  wire logic [`EXCONV_UIXT_W-1:0] idUIxt,
	output logic      [`EXCONV_DATA_W-1:0] clzVal,
	output logic                           clzHit
);

	localparam int W     = `EXCONV_DATA_W;
	localparam int OP_W  = `EXCONV_OP_W;
	localparam int CNT_W = 8;

	exConvPkg::convOp_e op;

	logic [CNT_W-1:0] cntLong;
	logic [CNT_W-1:0] cntQuad;
	logic [CNT_W-1:0] cntSel;

	// Priority scan over the low span bits of val.
	// The highest set bit wins, and an all-zero span counts as span.
	function automatic logic [CNT_W-1:0] clzScan(
		input logic [W-1:0] val,
		input int           span
	);
		logic [CNT_W-1:0] cnt;
		cnt = CNT_W'(span);
		for (int i = 0; i < W; i++) begin
			if ((i < span) && val[i]) begin
				cnt = CNT_W'(span - 1 - i);
			end
		end
		return cnt;
	endfunction

	assign op = exConvPkg::convOp_e'(idUIxt[OP_W-1:0]);

	// CLZ looks at the low long only, CLZQ at the full quad.
	assign cntLong = clzScan(regValRs, 32);
	assign cntQuad = clzScan(regValRs, W);

	always_comb begin
		case (op)
			exConvPkg::opClz: begin
				clzHit = 1'b1;
				cntSel = cntLong;
			end
			exConvPkg::opClzq: begin
				clzHit = 1'b1;
				cntSel = cntQuad;
			end
			default: begin
				clzHit = 1'b0;
				cntSel = '0;
			end
		endcase
	end

	// The count sits in the low byte of the result word.
	assign clzVal = {{(W-CNT_W){1'b0}}, cntSel};

endmodule

`default_nettype wire

//--- exConv2R.sv
// Combinational move, extend, NOT, immediate-high and sign-bit conversion unit.
`timescale 1ns/1ps
`default_nettype none

`include "exConv_settings.svh"

module exConv2R (
	input  wire logic [`EXCONV_DATA_W-1:0] regValRs,
	input  wire logic [`EXCONV_UIXT_W-1:0] idUIxt,
	output logic      [`EXCONV_DATA_W-1:0] convVal
);

	localparam int W    = `EXCONV_DATA_W;
	localparam int OP_W = `EXCONV_OP_W;

	exConvPkg::convOp_e op;

	// Candidate results, one per operation family.
	logic [W-1:0] extSb;
	logic [W-1:0] extSw;
	logic [W-1:0] extSl;
	logic [W-1:0] extUb;
	logic [W-1:0] extUw;
	logic [W-1:0] extUl;
	logic [W-1:0] notVal;
	logic [W-1:0] ldiHi;
	logic [W-1:0] ldiqHi;
	logic [W-1:0] ldiqHi16;
	logic [W-1:0] ldiqHi32;
	logic [W-1:0] fNeg;
	logic [W-1:0] fAbs;

	// Only the low field of the micro-index names the operation.
	assign op = exConvPkg::convOp_e'(idUIxt[OP_W-1:0]);

	// Sign extension replicates the top bit of the narrow field.
	assign extSb = {{(W-8){regValRs[7]}}, regValRs[7:0]};
	assign extSw = {{(W-16){regValRs[15]}}, regValRs[15:0]};
	assign extSl = {{(W-32){regValRs[31]}}, regValRs[31:0]};

	// Zero extension clears everything above the field.
	assign extUb = {{(W-8){1'b0}}, regValRs[7:0]};
	assign extUw = {{(W-16){1'b0}}, regValRs[15:0]};
	assign extUl = {{(W-32){1'b0}}, regValRs[31:0]};

	assign notVal = ~regValRs;

	// The immediate-high forms build the upper part of a constant
	// that a later operation fills in from below.
	assign ldiHi    = {regValRs[W-23:0], {22{1'b0}}};
	assign ldiqHi   = {regValRs[9:0], {(W-10){1'b0}}};
	assign ldiqHi16 = {regValRs[W-17:0], {16{1'b0}}};
	assign ldiqHi32 = {regValRs[W-33:0], {32{1'b0}}};

	// Floating negate and absolute value act on the sign bit alone.
	assign fNeg = {~regValRs[W-1], regValRs[W-2:0]};
	assign fAbs = {1'b0, regValRs[W-2:0]};

	// The leading-zero counter owns CLZ and CLZQ, so they fall to the zero default here.
	always_comb begin
		case (op)
			exConvPkg::opExtsb: begin
				convVal = extSb;
			end
			exConvPkg::opExtsw: begin
				convVal = extSw;
			end
			exConvPkg::opExtsl: begin
				convVal = extSl;
			end
			exConvPkg::opMov: begin
				convVal = regValRs;
			end
			exConvPkg::opExtub: begin
				convVal = extUb;
			end
			exConvPkg::opExtuw: begin
				convVal = extUw;
			end
			exConvPkg::opExtul: begin
				convVal = extUl;
			end
			exConvPkg::opNot: begin
				convVal = notVal;
			end
			exConvPkg::opLdihi: begin
				convVal = ldiHi;
			end
			exConvPkg::opLdiqhi: begin
				convVal = ldiqHi;
			end
			exConvPkg::opLdiqhi16: begin
				convVal = ldiqHi16;
			end
			exConvPkg::opLdiqhi32: begin
				convVal = ldiqHi32;
			end
			exConvPkg::opFneg: begin
				convVal = fNeg;
			end
			exConvPkg::opFabs: begin
				convVal = fAbs;
			end
			default: begin
				convVal = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- exConvPkg.sv
// Package with the conversion opcode enum shared by the lane units.
`default_nettype none

`include "exConv_settings.svh"

package exConvPkg;

	// Operation codes in the low bits of the micro-index.
	// Codes 16 and up are undefined and give a zero result.
	typedef enum logic [`EXCONV_OP_W-1:0] {
		// Sign extension of byte, word and long.
		opExtsb    = 6'd0,
		opExtsw    = 6'd1,
		opExtsl    = 6'd2,
		// Plain move.
		opMov      = 6'd3,
		// Zero extension of byte, word and long.
		opExtub    = 6'd4,
		opExtuw    = 6'd5,
		opExtul    = 6'd6,
		opNot      = 6'd7,
		// Leading-zero counts, handled by the counter unit.
		opClz      = 6'd8,
		opClzq     = 6'd9,
		// Immediate-high forms move a source slice to the top of the word.
		opLdihi    = 6'd10,
		opLdiqhi   = 6'd11,
		opLdiqhi16 = 6'd12,
		opLdiqhi32 = 6'd13,
		// Floating sign operations touch bit 63 only.
		opFneg     = 6'd14,
		opFabs     = 6'd15
	} convOp_e;

endpackage

`default_nettype wire

//--- exConv_settings.svh
// Width macros for the conversion lane: data word, micro-index and opcode field.
`ifndef EXCONV_SETTINGS_SVH
`define EXCONV_SETTINGS_SVH

// Width of the source operand and of the converted result.
`define EXCONV_DATA_W 64

// Width of the micro-index that arrives with each request.
`define EXCONV_UIXT_W 8

// The opcode sits in the low bits of the micro-index.
// The upper bits of the micro-index carry nothing for this lane.
`define EXCONV_OP_W 6

`endif
